// File: bench/execUnit_asserts.sv
module execUnit_asserts
	import execPkg::*;
(
	input logic   CLK,
	input logic   RSTb,
	input aluReqT aluReq,
	input aluResT aluRes,
	input commitT commit,
	input flagsT  flags
);

	int failCount = 0; // read by the testbench at the end

	commitFollowsWrite: assert property (@(posedge CLK) disable iff (!RSTb)
		aluRes.valid && aluRes.wrEn |=> commit.valid)
	else begin
		failCount++;
		$error("ALU write was not committed on the next cycle");
	end

	// no commit without a write one cycle before
	commitHasWrite: assert property (@(posedge CLK) disable iff (!RSTb)
		commit.valid |-> $past(aluRes.valid && aluRes.wrEn))
	else begin
		failCount++;
		$error("commit without a preceding ALU write");
	end

	flagsHold: assert property (@(posedge CLK) disable iff (!RSTb)
		!aluReq.valid |=> $stable(flags))
	else begin
		failCount++;
		$error("flags changed with no valid ALU request");
	end

	resetClears: assert property (@(posedge CLK)
		!RSTb |=> !commit.valid && !aluRes.valid)
	else begin
		failCount++;
		$error("commit or ALU result valid right after reset");
	end

endmodule

// File: bench/execUnit_tb.sv
`include "execUnit_cfg.svh"

module execUnit_tb
	import execPkg::*;
();

	localparam int FIELDS = 9; // columns per line of the data file
	localparam int MAX_LINES = 64;

	logic   CLK;
	logic   RSTb;
	logic   issue;
	instrT  instr;
	commitT commit;
	flagsT  flags;

	logic [`DATA_BITS-1:0] stim [FIELDS*MAX_LINES];
	int                    nLines = 0;
	integer                seed;
	commitT                commitQ [$];
	flagsT                 flagsQ [$];
	logic [1:0]            issueSeen; // issue seen by fetch, then by the ALU

	execUnit dut (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.issue  (issue),
		.instr  (instr),
		.commit (commit),
		.flags  (flags)
	);

	bind execUnit execUnit_asserts uAsserts (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.aluReq (aluReq),
		.aluRes (aluRes),
		.commit (commit),
		.flags  (flags)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkCommit(input commitT exp, input commitT act);
		if (act !== exp) begin
			abortRun($sformatf("Fail at %0t: commit expected rd %0d data %h, got rd %0d data %h",
				$time, exp.rd, exp.data, act.rd, act.data));
		end
	endtask

	task automatic checkFlags(input flagsT exp, input flagsT act);
		if (act !== exp) begin
			abortRun($sformatf("Fail at %0t: flags (vscz) expected %b, got %b", $time, exp, act));
		end
	endtask

	always @(posedge CLK) begin
		if (!RSTb) begin
			issueSeen <= '0;
		end else begin
			issueSeen <= {issueSeen[0], issue};
		end
	end

	// outputs are sampled mid-cycle
	always @(negedge CLK) begin
		if (dut.uAsserts.failCount != 0) begin
			abortRun("a bound assertion reported an error");
		end else if (RSTb) begin
			if (issueSeen[1]) begin
				checkFlags(flagsQ.pop_front(), flags);
			end
			if (commit.valid) begin
				if (commitQ.size() == 0) begin
					abortRun("a commit arrived when no commit was expected");
				end else begin
					checkCommit(commitQ.pop_front(), commit);
				end
			end
		end
	end

	initial begin
		int     pos;
		int     bubbles;
		instrT  nextInstr;
		commitT expCommit;

		seed = 32'h3f1d_010e;
		RSTb = 1'b0;
		issue = 1'b0;
		instr = '0;
		for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
			stim[i] = '1; // marks the end of the data
		end
		$readmemh("bench/execUnit_testdata.txt", stim);
		while (nLines < MAX_LINES && stim[nLines*FIELDS] != '1) begin
			nLines++;
		end
		if (nLines == 0) begin
			abortRun("no instructions found in bench/execUnit_testdata.txt");
		end

		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		checkFlags('0, flags); // reset state, nothing issued yet

		for (int n = 0; n < nLines; n++) begin
			pos = n * FIELDS;
			nextInstr.op = aluOpE'(stim[pos][4:0]);
			nextInstr.rd = stim[pos+1][`REG_IDX_BITS-1:0];
			nextInstr.rs = stim[pos+2][`REG_IDX_BITS-1:0];
			nextInstr.useImm = stim[pos+3][0];
			nextInstr.imm = stim[pos+4];
			@(posedge CLK);
			issue <= 1'b1;
			instr <= nextInstr;
			if (stim[pos+5][0]) begin
				expCommit.valid = 1'b1;
				expCommit.rd = nextInstr.rd;
				expCommit.data = stim[pos+6];
				commitQ.push_back(expCommit);
			end
			flagsQ.push_back(flagsT'(stim[pos+7][3:0]));
			if (!stim[pos+8][0]) begin
				bubbles = {$random(seed)} % 3; // chained lines get none
				repeat (bubbles) begin
					@(posedge CLK);
					issue <= 1'b0;
				end
			end
		end
		@(posedge CLK);
		issue <= 1'b0;

		while (flagsQ.size() != 0) begin
			@(negedge CLK);
		end
		repeat (2) @(posedge CLK); // commit trails the flags by one cycle
		if (commitQ.size() != 0) begin
			abortRun($sformatf("%0d expected commits never arrived", commitQ.size()));
		end else if (dut.uAsserts.failCount != 0) begin
			abortRun("a bound assertion failed during the run");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	initial begin
		wait (nLines != 0);
		repeat (nLines * 4 + 50) @(posedge CLK);
		abortRun("timeout, the instruction stream did not finish in time");
	end

endmodule

// File: bench/execUnit_testdata.txt
// op rd rs useImm imm  commit commitData  flags(vscz)  chain
// commit 0 means no commit expected, chain 1 issues the next line with no bubble
00 3 5 0 0000  1 0000  0 0
00 1 0 1 7fff  1 7fff  0 0
00 2 0 1 0001  1 0001  0 0
01 1 2 0 0000  1 8000  c 0
01 1 1 0 0000  1 0000  b 0
02 2 0 1 0010  1 0012  0 0
03 2 0 1 0013  1 ffff  6 0
04 2 0 1 0001  1 fffd  4 0
00 4 0 1 8000  1 8000  4 0
03 4 0 1 0001  1 7fff  8 0
0c 4 0 1 7fff  0 0000  1 0
0c 4 0 1 8000  0 0000  e 0
04 4 0 1 0000  1 7ffe  0 0
00 5 0 1 00f0  1 00f0  0 0
05 5 0 1 0f0f  1 0000  1 0
06 5 0 1 8001  1 8001  4 0
07 5 0 1 8001  1 0000  1 0
07 5 0 1 f00f  1 f00f  4 0
00 6 0 1 fffe  1 fffe  4 0
18 0 0 0 0000  0 0000  6 0
08 6 0 1 0003  1 fffa  4 0
09 6 0 1 0003  1 ffff  4 0
0e 6 0 1 0003  1 0002  0 0
00 8 0 1 1234  1 1234  0 0
0a 8 0 0 0000  1 4123  0 0
0b 8 0 0 0000  1 1234  0 0
0f 8 0 0 0000  1 3412  0 0
10 9 0 1 8002  1 c001  0 0
11 9 9 0 0000  1 6000  0 0
12 9 0 1 8000  1 0000  1 0
13 a 0 1 8001  1 0002  3 0
14 a 0 1 0002  1 8001  1 0
15 b 0 1 8001  1 0003  1 0
16 b 0 1 0003  1 8001  1 0
00 c 0 1 0005  1 0005  1 1
01 c c 0 0000  1 000a  0 1
01 d c 0 0000  1 000a  0 1
03 d c 0 0000  1 0000  1 0
1c 0 0 0 0000  0 0000  5 0
18 0 0 0 0000  0 0000  7 0
19 0 0 0 0000  0 0000  6 0
0d d 0 1 ffff  0 0000  7 0
1d e 0 0 0000  1 0007  7 0
1b 0 0 0 0000  0 0000  3 0
17 0 0 0 0000  0 0000  1 0
19 0 0 0 0000  0 0000  0 0
1a 0 0 0 0000  0 0000  1 0
0d e 0 1 0004  0 0000  0 0
1e 0 e 0 0000  0 0000  7 0
1f 0 0 0 0000  0 0000  7 0
1e 0 0 1 0002  0 0000  2 0
00 1 f 0 0000  1 0000  2 0

// File: list.f
+incdir+src
src/execPkg.sv
src/operandFetch.sv
src/alu.sv
src/regWriteBack.sv
src/execUnit.sv
bench/execUnit_asserts.sv
bench/execUnit_tb.sv

// File: src/alu.sv
`include "execUnit_cfg.svh"

module alu
	import execPkg::*;
(
	input  logic   CLK,
	input  logic   RSTb,
	input  aluReqT aluReq,
	output aluResT aluRes,
	output flagsT  flags
);

	logic [`DATA_BITS-1:0]          a;
	logic [`DATA_BITS-1:0]          b;
	logic                           aMsb;
	logic                           bMsb;
	logic [`DATA_BITS:0]            addW;
	logic [`DATA_BITS:0]            adcW;
	logic [`DATA_BITS:0]            subW;
	logic [`DATA_BITS:0]            sbbW;
	logic [`DATA_BITS:0]            arithW;
	logic                           isSub;
	logic signed [2*`DATA_BITS-1:0] sProd;
	logic [2*`DATA_BITS-1:0]        uProd;

	operandU resultNext;
	flagsT   flagsNext;
	logic    arithFlg;
	logic    logicFlg;
	logic    zeroFlg;

	logic                     resValid;
	logic [`REG_IDX_BITS-1:0] resRd;
	logic                     resWrEn;
	operandU                  resData;

	function automatic logic isZero(input logic [`DATA_BITS-1:0] v);
		return (v == '0);
	endfunction

	assign a = aluReq.a.data;
	assign b = aluReq.b.data;
	assign aMsb = a[`DATA_BITS-1];
	assign bMsb = b[`DATA_BITS-1];

	// top bit is carry out, or borrow for subtraction
	assign addW = {1'b0, a} + {1'b0, b};
	assign adcW = {1'b0, a} + {1'b0, b} + {{`DATA_BITS{1'b0}}, flags.c};
	assign subW = {1'b0, a} - {1'b0, b};
	assign sbbW = {1'b0, a} - {1'b0, b} - {{`DATA_BITS{1'b0}}, flags.c};

	assign sProd = $signed(a) * $signed(b);
	assign uProd = a * b;

	always_comb begin
		case (aluReq.op)
			opAdc: arithW = adcW;
			opSub, opCmp: arithW = subW;
			opSbb: arithW = sbbW;
			default: arithW = addW;
		endcase
	end

	assign isSub = (aluReq.op == opSub) || (aluReq.op == opSbb) || (aluReq.op == opCmp);

	always_comb begin
		flagsNext = flags; // flags hold unless the op says otherwise
		resultNext.data = '0;
		arithFlg = 1'b0;
		logicFlg = 1'b0;
		zeroFlg = 1'b0;

		case (aluReq.op)
			opMove: resultNext.data = b;
			opAdd, opAdc, opSub, opSbb: begin
				resultNext.data = arithW[`DATA_BITS-1:0];
				arithFlg = 1'b1;
			end
			opAnd: begin
				resultNext.data = a & b;
				logicFlg = 1'b1;
			end
			opOr: begin
				resultNext.data = a | b;
				logicFlg = 1'b1;
			end
			opXor: begin
				resultNext.data = a ^ b;
				logicFlg = 1'b1;
			end
			opMul: begin
				resultNext.data = sProd[`DATA_BITS-1:0];
				logicFlg = 1'b1;
			end
			opMulu: begin
				resultNext.data = sProd[2*`DATA_BITS-1:`DATA_BITS];
				logicFlg = 1'b1;
			end
			opRrn: resultNext.data = {a[3:0], a[`DATA_BITS-1:4]};
			opRln: resultNext.data = {a[`DATA_BITS-5:0], a[`DATA_BITS-1:`DATA_BITS-4]};
			opCmp: begin
				resultNext.data = a; // not written back
				arithFlg = 1'b1;
			end
			opTest: begin
				resultNext.data = a;
				flagsNext.z = isZero(a & b);
			end
			opUmulu: begin
				resultNext.data = uProd[2*`DATA_BITS-1:`DATA_BITS];
				logicFlg = 1'b1;
			end
			opBswap: resultNext.data = {a[7:0], a[`DATA_BITS-1:8]};
			opAsr: begin
				resultNext.data = {bMsb, b[`DATA_BITS-1:1]};
				zeroFlg = 1'b1;
			end
			opLsr: begin
				resultNext.data = {1'b0, b[`DATA_BITS-1:1]};
				zeroFlg = 1'b1;
			end
			opLsl: begin
				resultNext.data = {b[`DATA_BITS-2:0], 1'b0};
				zeroFlg = 1'b1;
			end
			opRolc: begin
				resultNext.data = {b[`DATA_BITS-2:0], flags.c};
				flagsNext.c = bMsb; // bit rotated out
			end
			opRorc: begin
				resultNext.data = {flags.c, b[`DATA_BITS-1:1]};
				flagsNext.c = b[0];
			end
			opRol: resultNext.data = {b[`DATA_BITS-2:0], bMsb};
			opRor: resultNext.data = {b[0], b[`DATA_BITS-1:1]};
			opClc: flagsNext.c = 1'b0;
			opStc: flagsNext.c = 1'b1;
			opClz: flagsNext.z = 1'b0;
			opStz: flagsNext.z = 1'b1;
			opCls: flagsNext.s = 1'b0;
			opSts: flagsNext.s = 1'b1;
			opStf: resultNext.flg = '{zero: '0, s: flags.s, c: flags.c, z: flags.z};
			opRsf: begin
				flagsNext.s = aluReq.b.flg.s;
				flagsNext.c = aluReq.b.flg.c;
				flagsNext.z = aluReq.b.flg.z;
			end
			default: ; // nop
		endcase

		if (arithFlg) begin
			flagsNext.c = arithW[`DATA_BITS];
			flagsNext.z = isZero(arithW[`DATA_BITS-1:0]);
			flagsNext.s = arithW[`DATA_BITS-1];
			// overflow when the result sign differs from A where it should not
			if (isSub) begin
				flagsNext.v = (aMsb ^ bMsb) & (aMsb ^ arithW[`DATA_BITS-1]);
			end else begin
				flagsNext.v = ~(aMsb ^ bMsb) & (aMsb ^ arithW[`DATA_BITS-1]);
			end
		end
		if (logicFlg) begin
			flagsNext.c = 1'b0;
			flagsNext.z = isZero(resultNext.data);
			flagsNext.s = resultNext.data[`DATA_BITS-1];
		end
		if (zeroFlg) begin
			flagsNext.z = isZero(resultNext.data);
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			resValid <= 1'b0;
			flags <= '0;
		end else begin
			resValid <= aluReq.valid;
			if (aluReq.valid) begin
				flags <= flagsNext;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (aluReq.valid) begin
			resRd <= aluReq.rd;
			resWrEn <= aluReq.wrEn;
			resData <= resultNext;
		end
	end

	assign aluRes = '{valid: resValid, rd: resRd, wrEn: resWrEn, data: resData};

endmodule

// File: src/execPkg.sv
`include "execUnit_cfg.svh"

package execPkg;

	typedef enum logic [4:0] {
		opMove  = 5'd0,
		opAdd   = 5'd1,
		opAdc   = 5'd2,
		opSub   = 5'd3,
		opSbb   = 5'd4,
		opAnd   = 5'd5,
		opOr    = 5'd6,
		opXor   = 5'd7,
		opMul   = 5'd8,  // low half of signed product
		opMulu  = 5'd9,  // high half of signed product
		opRrn   = 5'd10,
		opRln   = 5'd11,
		opCmp   = 5'd12,
		opTest  = 5'd13,
		opUmulu = 5'd14, // high half of unsigned product
		opBswap = 5'd15,
		opAsr   = 5'd16,
		opLsr   = 5'd17,
		opLsl   = 5'd18,
		opRolc  = 5'd19,
		opRorc  = 5'd20,
		opRol   = 5'd21,
		opRor   = 5'd22,
		opClc   = 5'd23,
		opStc   = 5'd24,
		opClz   = 5'd25,
		opStz   = 5'd26,
		opCls   = 5'd27,
		opSts   = 5'd28,
		opStf   = 5'd29, // store flags
		opRsf   = 5'd30, // restore flags
		opNop   = 5'd31
	} aluOpE;

	typedef struct packed {
		aluOpE                    op;
		logic [`REG_IDX_BITS-1:0] rd;     // destination, also operand A
		logic [`REG_IDX_BITS-1:0] rs;
		logic                     useImm;
		logic [`DATA_BITS-1:0]    imm;
	} instrT;

	typedef struct packed {
		logic v;
		logic s;
		logic c;
		logic z;
	} flagsT;

	// layout of the word written by store flags
	typedef struct packed {
		logic [`DATA_BITS-4:0] zero;
		logic                  s;
		logic                  c;
		logic                  z;
	} flagWordT;

	typedef union packed {
		logic [`DATA_BITS-1:0] data;
		flagWordT              flg;
	} operandU;

	typedef struct packed {
		aluOpE                    op;
		logic [`REG_IDX_BITS-1:0] rd;
		logic                     wrEn;
		operandU                  a;
		operandU                  b;
		logic                     valid;
	} aluReqT;

	typedef struct packed {
		logic                     valid;
		logic [`REG_IDX_BITS-1:0] rd;
		logic                     wrEn;
		operandU                  data;
	} aluResT;

	typedef struct packed {
		logic                     valid;
		logic [`REG_IDX_BITS-1:0] rd;
		logic [`DATA_BITS-1:0]    data;
	} commitT;

endpackage

// File: src/execUnit.sv
`include "execUnit_cfg.svh"

module execUnit
	import execPkg::*;
(
	input  logic   CLK,
	input  logic   RSTb,
	input  logic   issue,
	input  instrT  instr,
	output commitT commit,
	output flagsT  flags
);

	logic [`REG_IDX_BITS-1:0] rdAddrA;
	logic [`REG_IDX_BITS-1:0] rdAddrB;
	logic [`DATA_BITS-1:0]    rdDataA;
	logic [`DATA_BITS-1:0]    rdDataB;
	aluReqT                   aluReq;
	aluResT                   aluRes;

	// fetch stage, reads operands and forwards
	operandFetch uFetch (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.issue   (issue),
		.instr   (instr),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.aluRes  (aluRes),
		.aluReq  (aluReq)
	);

	alu uAlu (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.aluReq (aluReq),
		.aluRes (aluRes),
		.flags  (flags)
	);

	// register file and commit report
	regWriteBack uWriteBack (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.aluRes  (aluRes),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.commit  (commit)
	);

endmodule

// File: src/execUnit_cfg.svh
`ifndef EXECUNIT_CFG_SVH
`define EXECUNIT_CFG_SVH

// byte swap and nibble rotates are written for a 16-bit word
`define DATA_BITS 16

`define REG_COUNT 16
`define REG_IDX_BITS 4 // log2 of REG_COUNT

`endif

// File: src/operandFetch.sv
`include "execUnit_cfg.svh"

module operandFetch
	import execPkg::*;
(
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic                     issue,
	input  instrT                    instr,
	output logic [`REG_IDX_BITS-1:0] rdAddrA,
	output logic [`REG_IDX_BITS-1:0] rdAddrB,
	input  logic [`DATA_BITS-1:0]    rdDataA,
	input  logic [`DATA_BITS-1:0]    rdDataB,
	input  aluResT                   aluRes,
	output aluReqT                   aluReq
);

	logic    fetchValid;
	instrT   fetchInstr;
	logic    fwdA;
	logic    fwdB;
	logic    wrEn;
	operandU opA;
	operandU opB;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= issue; // no back-pressure, one slot
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			fetchInstr <= instr;
		end
	end

	assign rdAddrA = fetchInstr.rd;
	assign rdAddrB = fetchInstr.rs;

	// result one ahead has not reached the register file yet
	assign fwdA = aluRes.valid & aluRes.wrEn & (aluRes.rd == fetchInstr.rd);
	assign fwdB = aluRes.valid & aluRes.wrEn & (aluRes.rd == fetchInstr.rs);

	always_comb begin
		opA.data = fwdA ? aluRes.data.data : rdDataA;
		if (fetchInstr.useImm) begin
			opB.data = fetchInstr.imm;
		end else begin
			opB.data = fwdB ? aluRes.data.data : rdDataB;
		end
	end

	always_comb begin
		case (fetchInstr.op)
			opCmp, opTest, opRsf, opNop: wrEn = 1'b0;
			opClc, opStc, opClz, opStz: wrEn = 1'b0;
			opCls, opSts: wrEn = 1'b0; // flag-only ops
			default: wrEn = 1'b1;
		endcase
	end

	assign aluReq = '{
		op:    fetchInstr.op,
		rd:    fetchInstr.rd,
		wrEn:  wrEn,
		a:     opA,
		b:     opB,
		valid: fetchValid
	};

endmodule

// File: src/regWriteBack.sv
`include "execUnit_cfg.svh"

module regWriteBack
	import execPkg::*;
(
	input  logic                     CLK,
	input  logic                     RSTb,
	input  aluResT                   aluRes,
	input  logic [`REG_IDX_BITS-1:0] rdAddrA,
	input  logic [`REG_IDX_BITS-1:0] rdAddrB,
	output logic [`DATA_BITS-1:0]    rdDataA,
	output logic [`DATA_BITS-1:0]    rdDataB,
	output commitT                   commit
);

	logic [`DATA_BITS-1:0]    regFile [`REG_COUNT];
	logic                     wrHit;
	logic                     commitValid;
	logic [`REG_IDX_BITS-1:0] commitRd;
	logic [`DATA_BITS-1:0]    commitData;

	assign wrHit = aluRes.valid & aluRes.wrEn;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wrHit) begin
			regFile[aluRes.rd] <= aluRes.data.data;
		end
	end

	// read ports see the old value during the write cycle
	assign rdDataA = regFile[rdAddrA];
	assign rdDataB = regFile[rdAddrB];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			commitValid <= 1'b0;
		end else begin
			commitValid <= wrHit; // single-cycle pulse per write
		end
	end

	always_ff @(posedge CLK) begin
		if (wrHit) begin
			commitRd <= aluRes.rd;
			commitData <= aluRes.data.data;
		end
	end

	assign commit = '{valid: commitValid, rd: commitRd, data: commitData};

endmodule
